/* hdl/catalog_pkg.sv */
/*
 * product catalog types and the unit price table
 */
`default_nettype none

package catalog_pkg;

	typedef logic [3:0]  product_id_t;
	typedef logic [3:0]  quantity_t;
	typedef logic [7:0]  unit_price_t;
	// unit price times quantity, at most 255 * 15 = 3825
	typedef logic [11:0] line_price_t;

	// shown in the id field of a slot that holds nothing
	localparam product_id_t EMPTY_ID = 4'd15;

	// unit price of each product, indexed by product id
	localparam unit_price_t UNIT_PRICE [16] = '{
		8'd12,  8'd25,  8'd40,  8'd7,
		8'd99,  8'd150, 8'd255, 8'd18,
		8'd64,  8'd33,  8'd120, 8'd5,
		8'd200, 8'd75,  8'd49,  8'd0
	};

endpackage

`default_nettype wire

/* hdl/basket_pkg.sv */
/*
 * basket sizes, total and BCD types, and the slot structs
 */
`default_nettype none

package basket_pkg;

	localparam int SLOTS = 12;

	typedef logic [3:0]  slot_idx_t;
	// fill count, 0 to SLOTS
	typedef logic [3:0]  slot_count_t;
	// running total, at most 12 * 3825 = 45900
	typedef logic [15:0] total_t;

	localparam int LINE_DIGITS  = 4;
	localparam int TOTAL_DIGITS = 5;
	// binary widths the converters take for these digit counts
	localparam int LINE_BIN_W   = $clog2(10 ** LINE_DIGITS);
	localparam int TOTAL_BIN_W  = $clog2(10 ** TOTAL_DIGITS);

	typedef logic [4*LINE_DIGITS-1:0]  line_bcd_t;
	typedef logic [4*TOTAL_DIGITS-1:0] total_bcd_t;

	typedef struct packed {
		catalog_pkg::product_id_t id;
		catalog_pkg::quantity_t   qtt;
		catalog_pkg::line_price_t price;
	} basket_entry_t;

	typedef struct packed {
		catalog_pkg::product_id_t id;
		catalog_pkg::quantity_t   qtt;
		line_bcd_t                price;
	} slot_view_t;

	localparam basket_entry_t EMPTY_ENTRY = '{id: catalog_pkg::EMPTY_ID, qtt: '0, price: '0};

endpackage

`default_nettype wire

/* hdl/price_lookup.sv */
/*
 * two-stage price lookup: unit price fetch, then multiply by quantity
 */
`default_nettype none

module price_lookup (
	input  logic                      CLK,
	input  logic                      RESET_N,
	input  logic                      add,
	input  catalog_pkg::product_id_t  id,
	input  catalog_pkg::quantity_t    qtt,
	output basket_pkg::basket_entry_t entry,
	output logic                      entry_valid
);
	import catalog_pkg::*;

	logic        add_q;
	product_id_t id_q;
	quantity_t   qtt_q;
	unit_price_t unit_q;

	// first stage holds the request with its unit price
	always_ff @(posedge CLK) begin
		if (!RESET_N) begin
			add_q       <= 1'b0;
			entry_valid <= 1'b0;
		end else begin
			add_q       <= add;
			entry_valid <= add_q;
		end
	end

	always_ff @(posedge CLK) begin
		id_q        <= id;
		qtt_q       <= qtt;
		unit_q      <= UNIT_PRICE[id];
		// second stage prices the line
		entry.id    <= id_q;
		entry.qtt   <= qtt_q;
		entry.price <= line_price_t'(unit_q) * line_price_t'(qtt_q);
	end

endmodule

`default_nettype wire

/* hdl/basket_list.sv */
/*
 * ordered slot list with fill count and running total
 * append at the fill count, cancel removes a slot and shifts the rest down
 */
`default_nettype none

module basket_list (
	input  logic                                            CLK,
	input  logic                                            RESET_N,
	input  basket_pkg::basket_entry_t                       entry,
	input  logic                                            entry_valid,
	input  logic                                            cancel,
	input  basket_pkg::slot_idx_t                           cancel_slot,
	output basket_pkg::basket_entry_t [basket_pkg::SLOTS-1:0] slots,
	output basket_pkg::slot_count_t                         count,
	output basket_pkg::total_t                              total
);
	import basket_pkg::*;

	basket_entry_t [SLOTS-1:0] shifted;
	logic                      full;
	logic                      cancel_hit;
	total_t                    removed_price;
	total_t                    added_price;

	assign full       = (count == slot_count_t'(SLOTS));
	// only slots that are filled can be cancelled
	assign cancel_hit = cancel && (cancel_slot < count);

	assign added_price   = total_t'(entry.price);
	assign removed_price = total_t'(slots[cancel_slot].price);

	// list as it looks once cancel_slot has been taken out
	always_comb begin
		for (int i = 0; i < SLOTS - 1; i++) begin
			if (slot_idx_t'(i) < cancel_slot) begin
				shifted[i] = slots[i];
			end else begin
				shifted[i] = slots[i + 1];
			end
		end
		shifted[SLOTS-1] = EMPTY_ENTRY;
	end

	always_ff @(posedge CLK) begin
		if (!RESET_N) begin
			slots <= {SLOTS{EMPTY_ENTRY}};
			count <= '0;
			total <= '0;
		end else if (entry_valid) begin
			// an append wins over a cancel on the same edge
			// and is dropped when the basket is full
			if (!full) begin
				slots[count] <= entry;
				count        <= count + slot_count_t'(1);
				total        <= total + added_price;
			end
		end else if (cancel_hit) begin
			slots <= shifted;
			count <= count - slot_count_t'(1);
			total <= total - removed_price;
		end
	end

endmodule

`default_nettype wire

/* hdl/bcd_converter.sv */
/*
 * combinational binary to packed BCD conversion, double dabble
 */
`default_nettype none

module bcd_converter #(
	parameter int DIGITS = 4
) (
	input  logic [$clog2(10 ** DIGITS)-1:0] binary,
	output logic [4*DIGITS-1:0]             bcd
);
	localparam int BIN_W = $clog2(10 ** DIGITS);

	always_comb begin : dabble
		logic [4*DIGITS-1:0] acc;

		acc = '0;
		// msb first: fix up each digit, then shift in the next bit
		for (int i = BIN_W - 1; i >= 0; i--) begin
			for (int d = 0; d < DIGITS; d++) begin
				if (acc[4*d +: 4] > 4'd4) begin
					acc[4*d +: 4] = acc[4*d +: 4] + 4'd3;
				end
			end
			acc = {acc[4*DIGITS-2:0], binary[i]};
		end
		bcd = acc;
	end

endmodule

`default_nettype wire

/* hdl/basket_controller.sv */
/*
 * basket controller top: price lookup, slot list and BCD display conversion
 */
`default_nettype none

module basket_controller (
	input  logic                                          CLK,
	input  logic                                          RESET_N,
	input  logic                                          add,
	input  logic                                          cancel,
	input  catalog_pkg::product_id_t                      id,
	input  catalog_pkg::quantity_t                        qtt,
	output basket_pkg::slot_view_t [basket_pkg::SLOTS-1:0] slot_view,
	output basket_pkg::slot_count_t                       count,
	output basket_pkg::total_bcd_t                        total_bcd
);
	import basket_pkg::*;

	basket_entry_t             entry;
	logic                      entry_valid;
	basket_entry_t [SLOTS-1:0] slots;
	total_t                    total;

	price_lookup u_lookup (
		.CLK         (CLK),
		.RESET_N     (RESET_N),
		.add         (add),
		.id          (id),
		.qtt         (qtt),
		.entry       (entry),
		.entry_valid (entry_valid)
	);

	// on cancel the id input carries the slot index
	basket_list u_list (
		.CLK         (CLK),
		.RESET_N     (RESET_N),
		.entry       (entry),
		.entry_valid (entry_valid),
		.cancel      (cancel),
		.cancel_slot (id),
		.slots       (slots),
		.count       (count),
		.total       (total)
	);

	for (genvar i = 0; i < SLOTS; i++) begin : g_slot
		assign slot_view[i].id  = slots[i].id;
		assign slot_view[i].qtt = slots[i].qtt;

		bcd_converter #(.DIGITS(LINE_DIGITS)) u_line_bcd (
			.binary ({{(LINE_BIN_W - $bits(slots[i].price)){1'b0}}, slots[i].price}),
			.bcd    (slot_view[i].price)
		);
	end

	bcd_converter #(.DIGITS(TOTAL_DIGITS)) u_total_bcd (
		.binary ({{(TOTAL_BIN_W - $bits(total_t)){1'b0}}, total}),
		.bcd    (total_bcd)
	);

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
/*
 * testbench clock and reset source
 */
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic CLK,
	output logic RESET_N
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	// reset released just after an edge, like every other input
	initial begin
		RESET_N = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#2;
		RESET_N = 1'b1;
	end

endmodule

`default_nettype wire

/* dv/basket_tb.sv */
/*
 * basket controller testbench with a queue model of the basket,
 * directed tests, a watchdog and the summary line
 */
`default_nettype none

module basket_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import catalog_pkg::*;
	import basket_pkg::*;

	localparam int PERIOD_NS       = 20;
	localparam int NUM_TESTS       = 6;
	// the full basket test is the longest at about 60 cycles
	localparam int MAX_TEST_CYCLES = 100;
	localparam int TIMEOUT_NS      = (NUM_TESTS * MAX_TEST_CYCLES + 50) * PERIOD_NS;

	logic                      CLK;
	logic                      RESET_N;
	logic                      add;
	logic                      cancel;
	product_id_t               id;
	quantity_t                 qtt;
	slot_view_t [SLOTS-1:0]    slot_view;
	slot_count_t               count;
	total_bcd_t                total_bcd;

	basket_entry_t model[$];
	int    seed = 78;
	int    check_count = 0;
	int    error_count = 0;
	int    test_errors = 0;
	int    tests_run = 0;
	string current_test;

	tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(3)) u_clock (
		.CLK     (CLK),
		.RESET_N (RESET_N)
	);

	basket_controller DUT (
		.CLK       (CLK),
		.RESET_N   (RESET_N),
		.add       (add),
		.cancel    (cancel),
		.id        (id),
		.qtt       (qtt),
		.slot_view (slot_view),
		.count     (count),
		.total_bcd (total_bcd)
	);

	// decimal digits with the least significant one in the low nibble
	function automatic logic [19:0] to_bcd(input int value, input int digits);
		logic [19:0] r;
		int          v;

		r = '0;
		v = value;
		for (int d = 0; d < digits; d++) begin
			r[4*d +: 4] = 4'(v % 10);
			v = v / 10;
		end
		return r;
	endfunction

	task automatic next_cycle();
		@(posedge CLK);
		#2;
	endtask

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		if (exp !== act) begin
			$display("[ERROR] %s: %s expected %h actual %h", current_test, what, exp, act);
			error_count++;
			test_errors++;
		end
	endtask

	// compare every output with the model
	task automatic check_outputs();
		slot_view_t exp;
		int         sum;

		sum = 0;
		for (int i = 0; i < model.size(); i++) begin
			sum += int'(model[i].price);
		end
		check_value("count", 32'(model.size()), 32'(count));
		check_value("total_bcd", 32'(to_bcd(sum, TOTAL_DIGITS)), 32'(total_bcd));
		for (int i = 0; i < SLOTS; i++) begin
			if (i < model.size()) begin
				exp.id    = model[i].id;
				exp.qtt   = model[i].qtt;
				exp.price = line_bcd_t'(to_bcd(int'(model[i].price), LINE_DIGITS));
			end else begin
				exp = '{id: EMPTY_ID, qtt: '0, price: '0};
			end
			check_value($sformatf("slot %0d", i), 32'(exp), 32'(slot_view[i]));
		end
	endtask

	task automatic model_append(input product_id_t pid, input quantity_t q);
		basket_entry_t e;

		e.id    = pid;
		e.qtt   = q;
		e.price = line_price_t'(int'(UNIT_PRICE[pid]) * int'(q));
		if (model.size() < SLOTS) begin
			model.push_back(e);
		end
	endtask

	task automatic model_cancel(input int idx);
		if (idx < model.size()) begin
			model.delete(idx);
		end
	endtask

	// strobe followed by the two cycles of lookup latency
	task automatic do_add(input product_id_t pid, input quantity_t q);
		next_cycle();
		add = 1'b1;
		id  = pid;
		qtt = q;
		next_cycle();
		add = 1'b0;
		next_cycle();
		next_cycle();
	endtask

	task automatic do_cancel(input slot_idx_t idx);
		next_cycle();
		cancel = 1'b1;
		id     = idx;
		next_cycle();
		cancel = 1'b0;
	endtask

	task automatic random_item(output product_id_t pid, output quantity_t q);
		pid = product_id_t'($unsigned($random(seed)) % 15);
		q   = quantity_t'($unsigned($random(seed)) % 15 + 1);
	endtask

	task automatic start_test(input string name);
		current_test = name;
		test_errors  = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: passed", current_test);
		end else begin
			$display("test %s: %0d errors", current_test, test_errors);
		end
	endtask

	task automatic test_reset();
		start_test("reset");
		wait (RESET_N === 1'b1);
		check_outputs();
		finish_test();
	endtask

	task automatic test_single_adds();
		product_id_t pid;
		quantity_t   q;

		start_test("single_adds");
		for (int n = 0; n < 3; n++) begin
			random_item(pid, q);
			do_add(pid, q);
			model_append(pid, q);
			check_outputs();
		end
		finish_test();
	endtask

	task automatic test_back_to_back();
		product_id_t pid[3];
		quantity_t   q[3];

		start_test("back_to_back");
		for (int n = 0; n < 3; n++) begin
			random_item(pid[n], q[n]);
		end
		// one strobe on every cycle
		for (int n = 0; n < 3; n++) begin
			next_cycle();
			add = 1'b1;
			id  = pid[n];
			qtt = q[n];
			model_append(pid[n], q[n]);
		end
		next_cycle();
		add = 1'b0;
		next_cycle();
		next_cycle();
		check_outputs();
		finish_test();
	endtask

	task automatic test_cancel();
		slot_idx_t idx[5];

		start_test("cancel");
		idx[0] = slot_idx_t'(0);
		idx[1] = slot_idx_t'((model.size() - 1) / 2);
		idx[2] = slot_idx_t'(model.size() - 3);
		// these two are at or above the fill count
		idx[3] = slot_idx_t'(model.size() - 3);
		idx[4] = slot_idx_t'(15);
		for (int n = 0; n < 5; n++) begin
			do_cancel(idx[n]);
			model_cancel(int'(idx[n]));
			check_outputs();
		end
		finish_test();
	endtask

	task automatic test_same_edge();
		product_id_t pid;
		quantity_t   q;

		start_test("same_edge");
		random_item(pid, q);
		next_cycle();
		add = 1'b1;
		id  = pid;
		qtt = q;
		next_cycle();
		add = 1'b0;
		// the cancel reaches the list on the edge where the lookup is valid
		next_cycle();
		cancel = 1'b1;
		id     = slot_idx_t'(0);
		next_cycle();
		cancel = 1'b0;
		model_append(pid, q);
		check_outputs();
		finish_test();
	endtask

	task automatic test_full_basket();
		product_id_t pid;
		quantity_t   q;

		start_test("full_basket");
		while (model.size() > 0) begin
			do_cancel(slot_idx_t'(0));
			model_cancel(0);
			check_outputs();
		end
		for (int n = 0; n < SLOTS + 1; n++) begin
			random_item(pid, q);
			do_add(pid, q);
			model_append(pid, q);
			check_outputs();
		end
		finish_test();
	endtask

	initial begin
		add    = 1'b0;
		cancel = 1'b0;
		id     = '0;
		qtt    = '0;
		test_reset();
		test_single_adds();
		test_back_to_back();
		test_cancel();
		test_same_edge();
		test_full_basket();
		$display("tests run %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired before the tests finished");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* basket.f */
hdl/catalog_pkg.sv
hdl/basket_pkg.sv
hdl/price_lookup.sv
hdl/basket_list.sv
hdl/bcd_converter.sv
hdl/basket_controller.sv
dv/tb_clock.sv
dv/basket_tb.sv

/* Makefile */
# Verilator build and run for the basket controller testbench

VERILATOR ?= verilator
TOP       ?= basket_tb
FILELIST  ?= basket.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
